// File: Bender.yml
package:
  name: cpu_core

sources:
  - files:
      - common/isaPkg.sv
      - common/pipePkg.sv
      - design/fetch/fetchStage.sv
      - design/decode/decodeStage.sv
      - design/execute/executeStage.sv
      - design/memory/memoryStage.sv
      - design/hazardUnit.sv
      - design/cpuTop.sv
  - target: simulation
    files:
      - dv/cpuTop_props.sv
      - dv/cpuTb.sv

// File: common/isaPkg.sv
/*
 * MIPS subset definitions: add, sub, and, or, slt, addi, lw, sw, beq only.
 * Both memories are memWords deep and word addressed. Higher address bits wrap.
 */
package isaPkg;

	// data and instruction word
	typedef logic [31:0] wordT;

	// register file index
	typedef logic [4:0] regAddrT;

	// raw I-type immediate, sign extended in decode
	typedef logic [15:0] immT;

	// depth of instruction memory and of data memory
	localparam int memWords = 64;
	localparam int memAddrW = $clog2(memWords);

	// word index into either memory
	typedef logic [memAddrW-1:0] memAddrT;

	// primary opcode, instr[31:26]
	typedef enum logic [5:0] {
		rType = 6'h00,
		beq   = 6'h04,
		addi  = 6'h08,
		lw    = 6'h23,
		sw    = 6'h2b
	} opcodeT;

	// funct field of R-type, instr[5:0]
	// other codes (sll/nop included) decode to no write
	typedef enum logic [5:0] {
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24,
		fnOr  = 6'h25,
		fnSlt = 6'h2a
	} functT;

	// operation carried down to execute
	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluSlt
	} aluOpT;

endpackage

// File: common/pipePkg.sv
/*
 * Pipeline register layouts and hazard controls for the five-stage core.
 * All bundles clear to zero, which encodes a bubble.
 */
package pipePkg;

	// control bundle made by the main decoder
	typedef struct packed {
		logic          regWrite;
		logic          memToReg;
		logic          memWrite;
		logic          regDst;
		logic          aluSrc;
		isaPkg::aluOpT aluOp;
	} ctrlT;

	// IF/ID
	typedef struct packed {
		isaPkg::wordT instr;
		isaPkg::wordT pcPlus4;
	} ifIdT;

	// ID/EX, operands as read in decode, before forwarding
	typedef struct packed {
		ctrlT            ctrl;
		isaPkg::wordT    a;
		isaPkg::wordT    b;
		isaPkg::regAddrT rs;
		isaPkg::regAddrT rt;
		isaPkg::regAddrT rd;
		isaPkg::wordT    signImm;
	} idExT;

	// EX/MEM
	typedef struct packed {
		logic            regWrite;
		logic            memToReg;
		logic            memWrite;
		isaPkg::wordT    aluOut;
		isaPkg::wordT    writeData;
		isaPkg::regAddrT writeReg;
	} exMemT;

	// MEM/WB
	typedef struct packed {
		logic            regWrite;
		logic            memToReg;
		isaPkg::wordT    aluOut;
		isaPkg::wordT    readData;
		isaPkg::regAddrT writeReg;
	} memWbT;

	// where an execute operand comes from
	typedef enum logic [1:0] {
		fwdReg = 2'b00,
		fwdWb  = 2'b01,
		fwdMem = 2'b10
	} fwdSrcT;

	// hazard unit outputs, fanned out to every stage
	typedef struct packed {
		logic   stallF;
		logic   stallD;
		logic   flushD;
		logic   flushE;
		fwdSrcT forwardAE;
		fwdSrcT forwardBE;
		logic   forwardAD;
		logic   forwardBD;
	} hazardT;

endpackage

// File: design/cpuTop.sv
/*
 * Five-stage MIPS subset core. Program is loaded only while rst is high.
 * wbValid and storeValid are single-cycle strobes with no back-pressure.
 */
`timescale 1ns/1ns

module cpuTop (
	input  logic            clk,
	input  logic            rst,
	input  logic            progWe,
	input  isaPkg::memAddrT progAddr,
	input  isaPkg::wordT    progData,
	output logic            wbValid,
	output isaPkg::regAddrT wbReg,
	output isaPkg::wordT    wbData,
	output logic            storeValid,
	output isaPkg::memAddrT storeAddr,
	output isaPkg::wordT    storeData
);

	pipePkg::ifIdT   ifId;
	pipePkg::idExT   idEx;
	pipePkg::exMemT  exMem;
	pipePkg::memWbT  memWb;
	pipePkg::hazardT hz;
	logic            branchTaken;
	logic            isBranch;
	isaPkg::wordT    branchTarget;
	isaPkg::wordT    wbResult;
	isaPkg::regAddrT writeRegE;

	fetchStage uFetch (
		.clk(clk), .rst(rst),
		.progWe(progWe), .progAddr(progAddr), .progData(progData),
		.hz(hz), .branchTaken(branchTaken), .branchTarget(branchTarget),
		.ifId(ifId)
	);

	decodeStage uDecode (
		.clk(clk), .rst(rst),
		.ifId(ifId), .memWb(memWb), .wbResult(wbResult), .exAluOut(exMem.aluOut),
		.hz(hz), .branchTaken(branchTaken), .branchTarget(branchTarget),
		.idEx(idEx), .isBranch(isBranch)
	);

	executeStage uExecute (
		.clk(clk), .rst(rst),
		.idEx(idEx), .hz(hz), .exAluOut(exMem.aluOut), .wbResult(wbResult),
		.exMem(exMem), .writeRegE(writeRegE)
	);

	memoryStage uMemory (
		.clk(clk), .rst(rst),
		.exMem(exMem), .memWb(memWb), .wbResult(wbResult),
		.storeValid(storeValid), .storeAddr(storeAddr), .storeData(storeData)
	);

	hazardUnit uHazard (
		.ifId(ifId), .idEx(idEx), .writeRegE(writeRegE), .isBranch(isBranch),
		.exMem(exMem), .memWb(memWb), .hz(hz)
	);

	// writeback observation, writes to r0 are not reported
	assign wbValid = memWb.regWrite && memWb.writeReg != '0;
	assign wbReg   = memWb.writeReg;
	assign wbData  = wbResult;

endmodule

// File: design/decode/decodeStage.sv
/*
 * Main decoder, register file and beq resolution. r0 reads as zero.
 * Writeback in the same cycle is seen by reads through write-through.
 */
`timescale 1ns/1ns

module decodeStage (
	input  logic                clk,
	input  logic                rst,
	input  pipePkg::ifIdT       ifId,
	input  pipePkg::memWbT      memWb,
	input  isaPkg::wordT        wbResult,
	input  isaPkg::wordT        exAluOut,
	input  pipePkg::hazardT     hz,
	output logic                branchTaken,
	output isaPkg::wordT        branchTarget,
	output pipePkg::idExT       idEx,
	output logic                isBranch
);

	isaPkg::wordT    rf [32];
	isaPkg::opcodeT  opcode;
	isaPkg::functT   funct;
	isaPkg::regAddrT rs;
	isaPkg::regAddrT rt;
	isaPkg::regAddrT rd;
	isaPkg::immT     imm;
	isaPkg::wordT    signImm;
	isaPkg::wordT    rdA;
	isaPkg::wordT    rdB;
	isaPkg::wordT    cmpA;
	isaPkg::wordT    cmpB;
	pipePkg::ctrlT   ctrl;
	logic            isBeq;

	// instruction fields
	assign opcode = isaPkg::opcodeT'(ifId.instr[31:26]);
	assign funct  = isaPkg::functT'(ifId.instr[5:0]);
	assign rs     = ifId.instr[25:21];
	assign rt     = ifId.instr[20:16];
	assign rd     = ifId.instr[15:11];
	assign imm    = ifId.instr[15:0];

	assign signImm = {{16{imm[15]}}, imm};

	// main decoder
	always_comb begin
		ctrl  = '0;
		isBeq = 1'b0;
		case (opcode)
			isaPkg::rType: begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst   = 1'b1;
				case (funct)
					isaPkg::fnAdd: ctrl.aluOp = isaPkg::aluAdd;
					isaPkg::fnSub: ctrl.aluOp = isaPkg::aluSub;
					isaPkg::fnAnd: ctrl.aluOp = isaPkg::aluAnd;
					isaPkg::fnOr:  ctrl.aluOp = isaPkg::aluOr;
					isaPkg::fnSlt: ctrl.aluOp = isaPkg::aluSlt;
					// unsupported funct behaves as a nop
					default: ctrl.regWrite = 1'b0;
				endcase
			end
			isaPkg::lw: begin
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluSrc   = 1'b1;
			end
			isaPkg::sw: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc   = 1'b1;
			end
			isaPkg::addi: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc   = 1'b1;
			end
			isaPkg::beq: isBeq = 1'b1;
			default: ctrl = '0;
		endcase
	end

	// register file write from MEM/WB, r0 never written
	always_ff @(posedge clk) begin
		if (memWb.regWrite && memWb.writeReg != '0) begin
			rf[memWb.writeReg] <= wbResult;
		end
	end

	// reads with write-through
	assign rdA = (rs == '0) ? '0 :
		(memWb.regWrite && memWb.writeReg == rs) ? wbResult : rf[rs];
	assign rdB = (rt == '0) ? '0 :
		(memWb.regWrite && memWb.writeReg == rt) ? wbResult : rf[rt];

	// comparator, only the memory stage ALU result is forwarded here
	assign cmpA = hz.forwardAD ? exAluOut : rdA;
	assign cmpB = hz.forwardBD ? exAluOut : rdB;

	assign branchTaken  = isBeq && (cmpA == cmpB);
	assign branchTarget = ifId.pcPlus4 + {signImm[29:0], 2'b00};
	// hazard unit takes the taken result for its flush
	assign isBranch     = branchTaken;

	// ID/EX, flushE inserts a bubble
	always_ff @(posedge clk) begin
		if (rst || hz.flushE) begin
			idEx <= '0;
		end else begin
			idEx.ctrl    <= ctrl;
			idEx.a       <= rdA;
			idEx.b       <= rdB;
			idEx.rs      <= rs;
			idEx.rt      <= rt;
			idEx.rd      <= rd;
			idEx.signImm <= signImm;
		end
	end

endmodule

// File: design/execute/executeStage.sv
/*
 * Forwarding muxes, ALU and destination select. slt compares signed.
 * Forwarded values come from EX/MEM aluOut and the writeback result.
 */
`timescale 1ns/1ns

module executeStage (
	input  logic                clk,
	input  logic                rst,
	input  pipePkg::idExT       idEx,
	input  pipePkg::hazardT     hz,
	input  isaPkg::wordT        exAluOut,
	input  isaPkg::wordT        wbResult,
	output pipePkg::exMemT      exMem,
	output isaPkg::regAddrT     writeRegE
);

	isaPkg::wordT srcA;
	isaPkg::wordT srcB;
	isaPkg::wordT writeData;
	isaPkg::wordT aluOut;

	// operand A
	always_comb begin
		case (hz.forwardAE)
			pipePkg::fwdMem: srcA = exAluOut;
			pipePkg::fwdWb:  srcA = wbResult;
			default:         srcA = idEx.a;
		endcase
	end

	// operand B before the immediate mux, this is also store data
	always_comb begin
		case (hz.forwardBE)
			pipePkg::fwdMem: writeData = exAluOut;
			pipePkg::fwdWb:  writeData = wbResult;
			default:         writeData = idEx.b;
		endcase
	end

	assign srcB = idEx.ctrl.aluSrc ? idEx.signImm : writeData;

	always_comb begin
		case (idEx.ctrl.aluOp)
			isaPkg::aluAdd: aluOut = srcA + srcB;
			isaPkg::aluSub: aluOut = srcA - srcB;
			isaPkg::aluAnd: aluOut = srcA & srcB;
			isaPkg::aluOr:  aluOut = srcA | srcB;
			isaPkg::aluSlt: aluOut = {31'd0, $signed(srcA) < $signed(srcB)};
			default:        aluOut = '0;
		endcase
	end

	// rd for R-type, rt for addi and lw
	assign writeRegE = idEx.ctrl.regDst ? idEx.rd : idEx.rt;

	// EX/MEM
	always_ff @(posedge clk) begin
		if (rst) begin
			exMem <= '0;
		end else begin
			exMem.regWrite  <= idEx.ctrl.regWrite;
			exMem.memToReg  <= idEx.ctrl.memToReg;
			exMem.memWrite  <= idEx.ctrl.memWrite;
			exMem.aluOut    <= aluOut;
			exMem.writeData <= writeData;
			exMem.writeReg  <= writeRegE;
		end
	end

endmodule

// File: design/fetch/fetchStage.sv
/*
 * PC and instruction memory. progWe is accepted only while rst is high.
 * IF/ID holds on stallD and clears on flushD.
 */
`timescale 1ns/1ns

module fetchStage (
	input  logic                clk,
	input  logic                rst,
	input  logic                progWe,
	input  isaPkg::memAddrT     progAddr,
	input  isaPkg::wordT        progData,
	input  pipePkg::hazardT     hz,
	input  logic                branchTaken,
	input  isaPkg::wordT        branchTarget,
	output pipePkg::ifIdT       ifId
);

	isaPkg::wordT imem [isaPkg::memWords];
	isaPkg::wordT pc;
	isaPkg::wordT pcPlus4;
	isaPkg::wordT pcNext;
	isaPkg::wordT fetched;

	// program load port, one word per strobe
	always_ff @(posedge clk) begin
		if (rst && progWe) begin
			imem[progAddr] <= progData;
		end
	end

	// byte pc, word indexed memory
	assign fetched = imem[pc[2 +: isaPkg::memAddrW]];
	assign pcPlus4 = pc + 32'd4;

	// branch resolved in decode redirects the next fetch
	assign pcNext = branchTaken ? branchTarget : pcPlus4;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
		end else if (!hz.stallF) begin
			pc <= pcNext;
		end
	end

	// IF/ID, flush squashes the wrong-path fetch after a taken beq
	always_ff @(posedge clk) begin
		if (rst || hz.flushD) begin
			ifId <= '0;
		end else if (!hz.stallD) begin
			ifId.instr   <= fetched;
			ifId.pcPlus4 <= pcPlus4;
		end
	end

endmodule

// File: design/hazardUnit.sv
/*
 * Forwarding selects, load-use and beq operand stalls, taken-branch flush.
 * Memory stage wins over writeback. r0 is never forwarded.
 */
`timescale 1ns/1ns

module hazardUnit (
	input  pipePkg::ifIdT       ifId,
	input  pipePkg::idExT       idEx,
	input  isaPkg::regAddrT     writeRegE,
	input  logic                isBranch,
	input  pipePkg::exMemT      exMem,
	input  pipePkg::memWbT      memWb,
	output pipePkg::hazardT     hz
);

	isaPkg::regAddrT rsD;
	isaPkg::regAddrT rtD;
	logic            beqD;
	logic            lwStall;
	logic            branchStall;
	logic            stall;

	assign rsD  = ifId.instr[25:21];
	assign rtD  = ifId.instr[20:16];
	assign beqD = isaPkg::opcodeT'(ifId.instr[31:26]) == isaPkg::beq;

	// execute operands
	always_comb begin
		hz.forwardAE = pipePkg::fwdReg;
		hz.forwardBE = pipePkg::fwdReg;
		if (idEx.rs != '0 && exMem.regWrite && exMem.writeReg == idEx.rs) begin
			hz.forwardAE = pipePkg::fwdMem;
		end else if (idEx.rs != '0 && memWb.regWrite && memWb.writeReg == idEx.rs) begin
			hz.forwardAE = pipePkg::fwdWb;
		end
		if (idEx.rt != '0 && exMem.regWrite && exMem.writeReg == idEx.rt) begin
			hz.forwardBE = pipePkg::fwdMem;
		end else if (idEx.rt != '0 && memWb.regWrite && memWb.writeReg == idEx.rt) begin
			hz.forwardBE = pipePkg::fwdWb;
		end
	end

	// comparator operands, writeback is covered by write-through
	assign hz.forwardAD = rsD != '0 && exMem.regWrite && exMem.writeReg == rsD;
	assign hz.forwardBD = rtD != '0 && exMem.regWrite && exMem.writeReg == rtD;

	// load in execute feeding the instruction in decode
	assign lwStall = idEx.ctrl.memToReg && writeRegE != '0 &&
		(writeRegE == rsD || writeRegE == rtD);

	// beq operand still in execute, or a load result still in memory
	assign branchStall = beqD && (
		(idEx.ctrl.regWrite && writeRegE != '0 &&
			(writeRegE == rsD || writeRegE == rtD)) ||
		(exMem.memToReg && exMem.writeReg != '0 &&
			(exMem.writeReg == rsD || exMem.writeReg == rtD)));

	assign stall = lwStall || branchStall;

	assign hz.stallF = stall;
	assign hz.stallD = stall;
	assign hz.flushE = stall;
	// a stalled beq compared stale operands, so no flush then
	assign hz.flushD = isBranch && !stall;

endmodule

// File: design/memory/memoryStage.sv
/*
 * Data memory with asynchronous read, addressed by aluOut word index.
 * Store strobe is combinational from EX/MEM and lasts one cycle.
 */
`timescale 1ns/1ns

module memoryStage (
	input  logic                clk,
	input  logic                rst,
	input  pipePkg::exMemT      exMem,
	output pipePkg::memWbT      memWb,
	output isaPkg::wordT        wbResult,
	output logic                storeValid,
	output isaPkg::memAddrT     storeAddr,
	output isaPkg::wordT        storeData
);

	isaPkg::wordT    dmem [isaPkg::memWords];
	isaPkg::memAddrT addr;
	isaPkg::wordT    readData;

	// byte address from ALU, low two bits ignored
	assign addr = exMem.aluOut[2 +: isaPkg::memAddrW];

	always_ff @(posedge clk) begin
		if (exMem.memWrite) begin
			dmem[addr] <= exMem.writeData;
		end
	end

	assign readData = dmem[addr];

	// store observation
	assign storeValid = exMem.memWrite;
	assign storeAddr  = addr;
	assign storeData  = exMem.writeData;

	// MEM/WB
	always_ff @(posedge clk) begin
		if (rst) begin
			memWb <= '0;
		end else begin
			memWb.regWrite <= exMem.regWrite;
			memWb.memToReg <= exMem.memToReg;
			memWb.aluOut   <= exMem.aluOut;
			memWb.readData <= readData;
			memWb.writeReg <= exMem.writeReg;
		end
	end

	// loads take memory data, everything else the ALU result
	assign wbResult = memWb.memToReg ? memWb.readData : memWb.aluOut;

endmodule

// File: dv/cpuTb.sv
/*
 * Testbench for cpuTop. Program and expected events come from dv/programInput.txt.
 * rst stays high while the program loads, then for 3 more cycles.
 */
`timescale 1ns/1ns

module cpuTb;

	localparam int stimWords   = 256;
	localparam int waitCycles  = 400;
	localparam int drainCycles = 20;
	localparam int driveDelay  = 10;

	// one expected writeback
	typedef struct packed {
		isaPkg::regAddrT regIdx;
		isaPkg::wordT    data;
	} wbEventT;

	// one expected store
	typedef struct packed {
		isaPkg::memAddrT addr;
		isaPkg::wordT    data;
	} storeEventT;

	logic            clk;
	logic            rst;
	logic            progWe;
	isaPkg::memAddrT progAddr;
	isaPkg::wordT    progData;
	logic            wbValid;
	isaPkg::regAddrT wbReg;
	isaPkg::wordT    wbData;
	logic            storeValid;
	isaPkg::memAddrT storeAddr;
	isaPkg::wordT    storeData;

	// raw words of the data file
	isaPkg::wordT stim [stimWords];

	// expected events in program order with one queue per kind
	wbEventT    expWb [$];
	storeEventT expStore [$];

	int errCount;
	int passCount;
	int eventCount;
	int expectedEvents;

	cpuTop dut (
		.clk(clk), .rst(rst),
		.progWe(progWe), .progAddr(progAddr), .progData(progData),
		.wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
		.storeValid(storeValid), .storeAddr(storeAddr), .storeData(storeData)
	);

	always #50 clk = ~clk;

	// one writeback event against the head of its queue
	task automatic checkWb(input isaPkg::regAddrT r, input isaPkg::wordT d);
		wbEventT head;
		bit      bad;
		bad = 1'b0;
		eventCount++;
		if (expWb.size() == 0) begin
			$display("%0t: extra writeback to r%0d after all expected writebacks", $time, r);
			errCount++;
		end else begin
			head = expWb.pop_front();
			if (r !== head.regIdx) begin
				$display("[ERROR] %0t wbReg: got %0d, expected %0d", $time, r, head.regIdx);
				bad = 1'b1;
			end
			if (d !== head.data) begin
				$display("[ERROR] %0t wbData: got %h, expected %h", $time, d, head.data);
				bad = 1'b1;
			end
			if (bad) begin
				errCount++;
			end else begin
				passCount++;
				$display("%0t: writeback r%0d = %h ok", $time, r, d);
			end
		end
	endtask

	// one store event against the head of its queue
	task automatic checkStore(input isaPkg::memAddrT a, input isaPkg::wordT d);
		storeEventT head;
		bit         bad;
		bad = 1'b0;
		eventCount++;
		if (expStore.size() == 0) begin
			$display("%0t: extra store to word %0d after all expected stores", $time, a);
			errCount++;
		end else begin
			head = expStore.pop_front();
			if (a !== head.addr) begin
				$display("[ERROR] %0t storeAddr: got %0d, expected %0d", $time, a, head.addr);
				bad = 1'b1;
			end
			if (d !== head.data) begin
				$display("[ERROR] %0t storeData: got %h, expected %h", $time, d, head.data);
				bad = 1'b1;
			end
			if (bad) begin
				errCount++;
			end else begin
				passCount++;
				$display("%0t: store word %0d = %h ok", $time, a, d);
			end
		end
	endtask

	// strobes sampled on the falling edge in mid-cycle
	always @(negedge clk) begin
		if (!rst && wbValid) begin
			checkWb(wbReg, wbData);
		end
		if (!rst && storeValid) begin
			checkStore(storeAddr, storeData);
		end
	end

	// one word per cycle through the load port while rst is high
	task automatic loadProgram(input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
			#driveDelay;
			progWe   = 1'b1;
			progAddr = isaPkg::memAddrT'(i);
			progData = stim[1 + i];
		end
		@(posedge clk);
		#driveDelay;
		progWe = 1'b0;
	endtask

	initial begin
		int         progLen;
		int         base;
		int         cycles;
		wbEventT    wbEv;
		storeEventT stEv;
		clk = 1'b0;
		rst = 1'b1;
		progWe = 1'b0;
		progAddr = '0;
		progData = '0;
		errCount = 0;
		passCount = 0;
		eventCount = 0;
		expectedEvents = 0;
		$readmemh("dv/programInput.txt", stim);
		progLen = stim[0];
		base = progLen + 1;
		if ($isunknown(stim[0]) || progLen < 1 || progLen > isaPkg::memWords) begin
			$display("stimulus file is missing or gives an invalid program length");
			errCount++;
		end else if ($isunknown(stim[base]) || base + 3 * int'(stim[base]) >= stimWords) begin
			$display("stimulus file gives no valid event count after the program");
			errCount++;
		end else begin
			expectedEvents = stim[base];
			// kind 1 is a writeback and kind 2 a store
			for (int i = 0; i < expectedEvents; i++) begin
				case (stim[base + 1 + 3 * i])
					32'd1: begin
						wbEv.regIdx = isaPkg::regAddrT'(stim[base + 2 + 3 * i]);
						wbEv.data   = stim[base + 3 + 3 * i];
						expWb.push_back(wbEv);
					end
					32'd2: begin
						stEv.addr = isaPkg::memAddrT'(stim[base + 2 + 3 * i]);
						stEv.data = stim[base + 3 + 3 * i];
						expStore.push_back(stEv);
					end
					default: begin
						$display("event %0d in the stimulus file has an unknown kind", i);
						errCount++;
					end
				endcase
			end
			loadProgram(progLen);
			for (int i = 0; i < 3; i++) begin
				@(posedge clk);
			end
			#driveDelay;
			rst = 1'b0;
			// run until every expected event has been seen
			cycles = 0;
			while (expWb.size() + expStore.size() > 0 && cycles < waitCycles) begin
				@(posedge clk);
				cycles++;
			end
			if (expWb.size() + expStore.size() > 0) begin
				$display("timeout after %0d cycles: %0d writeback and %0d store events never came",
					cycles, expWb.size(), expStore.size());
				errCount++;
			end
			// the self-loop must stay quiet
			for (int i = 0; i < drainCycles; i++) begin
				@(posedge clk);
			end
			if (eventCount != expectedEvents) begin
				$display("saw %0d events but the stimulus file lists %0d", eventCount, expectedEvents);
				errCount++;
			end
		end
		// bound assertion failures count against the run
		if (dut.props.failCount > 0) begin
			$display("%0d bound assertion checks failed during the run", dut.props.failCount);
			errCount += dut.props.failCount;
		end
		$display("summary: %0d passed, %0d failed, %0d of %0d events seen",
			passCount, errCount, eventCount, expectedEvents);
		if (errCount == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: dv/cpuTop_props.sv
/*
 * Concurrent checks bound into cpuTop. The stall and PC are reached
 * through hierarchical names inside cpuTop.
 */
`timescale 1ns/1ns

module cpuTopProps (
	input logic            clk,
	input logic            rst,
	input logic            wbValid,
	input isaPkg::regAddrT wbReg,
	input logic            storeValid,
	input logic            stallF,
	input isaPkg::wordT    pc
);

	// number of failed assertions for the testbench summary
	int failCount = 0;

	// pipeline registers are clear one cycle into reset
	noStrobeInReset: assert property (@(posedge clk)
		rst && $past(rst) |-> !wbValid && !storeValid)
		else begin
			$error("writeback or store strobe during reset");
			failCount++;
		end

	// r0 writes are never reported
	wbRegNonZero: assert property (@(posedge clk) disable iff (rst)
		wbValid |-> wbReg != '0)
		else begin
			$error("wbValid high with wbReg zero");
			failCount++;
		end

	// a stalled fetch keeps its pc
	pcHoldOnStall: assert property (@(posedge clk) disable iff (rst)
		stallF |=> $stable(pc))
		else begin
			$error("pc moved while stallF was high");
			failCount++;
		end

endmodule

bind cpuTop cpuTopProps props (
	.clk(clk), .rst(rst),
	.wbValid(wbValid), .wbReg(wbReg), .storeValid(storeValid),
	.stallF(hz.stallF), .pc(uFetch.pc)
);

// File: dv/programInput.txt
// hex words: program length, then one instruction per line
// then event count, then events as: kind (1 writeback, 2 store), reg or word addr, value
17
20010005 // addi r1, r0, 5
2002000c // addi r2, r0, 12
00221820 // add  r3, r1, r2
00612022 // sub  r4, r3, r1
00822824 // and  r5, r4, r2
00223025 // or   r6, r1, r2
0022382a // slt  r7, r1, r2
0041402a // slt  r8, r2, r1
2009fffd // addi r9, r0, -3
0121502a // slt  r10, r9, r1
ac030008 // sw   r3, 8(r0)
8c0b0008 // lw   r11, 8(r0)
01616020 // add  r12, r11, r1, load-use
11840001 // beq  r12, r4, +1, not taken
200d0007 // addi r13, r0, 7
11ad0001 // beq  r13, r13, +1, taken
200e0063 // addi r14, r0, 99, skipped
8c0f0008 // lw   r15, 8(r0)
11eb0001 // beq  r15, r11, +1, taken after load
20100001 // addi r16, r0, 1, skipped
2011002a // addi r17, r0, 42
ac11000c // sw   r17, 12(r0)
1000ffff // beq  r0, r0, -1, self-loop
11
1 01 00000005
1 02 0000000c
1 03 00000011
1 04 0000000c
1 05 0000000c
1 06 0000000d
1 07 00000001
1 08 00000000
1 09 fffffffd
1 0a 00000001
2 02 00000011
1 0b 00000011
1 0c 00000016
1 0d 00000007
1 0f 00000011
1 11 0000002a
2 03 0000002a

// File: files.f
common/isaPkg.sv
common/pipePkg.sv
design/fetch/fetchStage.sv
design/decode/decodeStage.sv
design/execute/executeStage.sv
design/memory/memoryStage.sv
design/hazardUnit.sv
design/cpuTop.sv
dv/cpuTop_props.sv
dv/cpuTb.sv
